//--- hdl/audio_pkg.sv
package audio_pkg;

    // One signed PCM sample.
    typedef logic signed [23:0] sample_t;

    // Channel flag, 0 is left.
    typedef logic [0:0] ch_idx_t;

    localparam int NUM_CH = 2;

    // I2S framing.
    localparam int BCK_HALF  = 2;  // Cycles per bck half period.
    localparam int SLOT_BITS = 32; // Bit clocks per channel slot.

    // Per-channel queue.
    localparam int FIFO_DEPTH = 4;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_LEFT,
        SER_RIGHT
    } ser_state_t;

endpackage

//--- hdl/chan_link_if.sv
`timescale 1ns/100ps

interface chan_link_if import audio_pkg::*; ();

    // Feeder to channel.
    sample_t in_sample;
    logic    in_stb;
    logic    flush;     // Level, empties the channel.

    // Channel to drain.
    sample_t out_sample; // Queue head.
    logic    out_avail;
    logic    out_pop;   // Only while out_avail is high.

    modport feeder (
        output in_sample,
        output in_stb,
        output flush
    );

    modport channel (
        input  in_sample,
        input  in_stb,
        input  flush,
        output out_sample,
        output out_avail,
        input  out_pop
    );

    modport drain (
        input  out_sample,
        input  out_avail,
        output out_pop
    );

endinterface

//--- hdl/frame_demux.sv
`timescale 1ns/100ps

module frame_demux import audio_pkg::*; (
    input  logic        clk245760,
    input  logic        rst,
    input  logic        locked_i,
    input  sample_t     sample_i,
    input  ch_idx_t     sample_ch_i,
    input  logic        sample_stb_i,
    chan_link_if.feeder links [NUM_CH]
);

    sample_t           sample_q;
    logic [NUM_CH-1:0] stb_q;
    logic              flush_q;

    // Strobes are held off until flush has dropped again after relock.
    always_ff @(posedge clk245760) begin
        if (rst) begin
            stb_q   <= '0;
            flush_q <= 1'b0;
        end else begin
            flush_q <= !locked_i;
            for (int i = 0; i < NUM_CH; i++) begin
                stb_q[i] <= sample_stb_i && locked_i && !flush_q &&
                            (sample_ch_i == ch_idx_t'(i));
            end
        end
    end

    always_ff @(posedge clk245760) begin
        if (sample_stb_i) begin
            sample_q <= sample_i;
        end
    end

    for (genvar i = 0; i < NUM_CH; i++) begin : g_link
        assign links[i].in_sample = sample_q;
        assign links[i].in_stb    = stb_q[i];
        assign links[i].flush     = flush_q;
    end

    // A push racing a flush would be lost in the channel.
    a_no_stb_in_flush: assert property (
        @(posedge clk245760) disable iff (rst)
        flush_q |-> (stb_q == '0)
    );

endmodule

//--- hdl/interp2x_ch.sv
`timescale 1ns/100ps

module interp2x_ch import audio_pkg::*; (
    input  logic         clk245760,
    input  logic         rst,
    chan_link_if.channel link
);

    sample_t prev_q;
    sample_t pend_q;       // New sample, written one cycle after the midpoint.
    logic    pend_vld_q;

    logic signed [24:0] sum;
    sample_t            mid;

    sample_t mem_q [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count_q;

    logic    push;
    logic    pop;
    sample_t push_data;

    // Sign extended sum, top 24 bits give floor((a + b) / 2).
    assign sum = {prev_q[23], prev_q} + {link.in_sample[23], link.in_sample};
    assign mid = sum[24:1];

    assign push      = link.in_stb || pend_vld_q;
    assign push_data = link.in_stb ? mid : pend_q;
    assign pop       = link.out_pop;

    always_ff @(posedge clk245760) begin
        if (rst || link.flush) begin
            prev_q     <= '0;
            pend_vld_q <= 1'b0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
        end else begin
            pend_vld_q <= link.in_stb;
            if (link.in_stb) begin
                prev_q <= link.in_sample;
            end
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // Depth is a power of two.
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk245760) begin
        if (link.in_stb) begin
            pend_q <= link.in_sample;
        end
        if (push) begin
            mem_q[wr_ptr_q] <= push_data;
        end
    end

    assign link.out_sample = mem_q[rd_ptr_q];
    assign link.out_avail  = (count_q != '0);

    // Input pacing must leave room for both words.
    a_no_push_full: assert property (
        @(posedge clk245760) disable iff (rst || link.flush)
        push |-> (count_q != FIFO_DEPTH)
    );

    a_pop_avail: assert property (
        @(posedge clk245760) disable iff (rst)
        link.out_pop |-> link.out_avail
    );

endmodule

//--- hdl/i2s_serializer.sv
`timescale 1ns/100ps

module i2s_serializer import audio_pkg::*; (
    input  logic       clk245760,
    input  logic       rst,
    chan_link_if.drain links [NUM_CH],
    output logic       i2s_bck_o,
    output logic       i2s_lrck_o,
    output logic       i2s_data_o
);

    ser_state_t state_q;

    logic [$clog2(2*BCK_HALF)-1:0] div_q;  // Cycle within one bit.
    logic [$clog2(SLOT_BITS)-1:0]  bit_q;  // Bit within the slot.
    logic [SLOT_BITS-1:0]          shift_q;

    logic              bit_end;
    logic              slot_start;
    ch_idx_t           next_ch;
    logic [NUM_CH-1:0] avail;
    logic [NUM_CH-1:0] pop;
    sample_t           head [NUM_CH];

    for (genvar i = 0; i < NUM_CH; i++) begin : g_link
        assign avail[i]         = links[i].out_avail;
        assign head[i]          = links[i].out_sample;
        assign pop[i]           = slot_start && (next_ch == ch_idx_t'(i)) && avail[i];
        assign links[i].out_pop = pop[i];
    end

    assign bit_end    = (div_q == 2*BCK_HALF-1);
    assign slot_start = (state_q == SER_IDLE) || (bit_end && bit_q == SLOT_BITS-1);
    assign next_ch    = (state_q == SER_LEFT) ? ch_idx_t'(1) : ch_idx_t'(0);

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state_q    <= SER_IDLE;
            div_q      <= '0;
            bit_q      <= '0;
            i2s_bck_o  <= 1'b0;
            i2s_lrck_o <= 1'b0;
            i2s_data_o <= 1'b0;
        end else if (slot_start) begin
            state_q    <= (next_ch == ch_idx_t'(1)) ? SER_RIGHT : SER_LEFT;
            div_q      <= '0;
            bit_q      <= '0;
            i2s_bck_o  <= 1'b0;
            i2s_lrck_o <= next_ch[0];
            i2s_data_o <= 1'b0;  // One-bit delay before the MSB.
        end else begin
            div_q <= div_q + 1'b1;
            if (div_q == BCK_HALF-1) begin
                i2s_bck_o <= 1'b1; // DAC samples here.
            end
            if (bit_end) begin
                div_q      <= '0;
                bit_q      <= bit_q + 1'b1;
                i2s_bck_o  <= 1'b0;
                i2s_data_o <= shift_q[SLOT_BITS-1];
            end
        end
    end

    // Sample MSB first, then zero padding. Underrun sends silence.
    always_ff @(posedge clk245760) begin
        if (slot_start) begin
            if (avail[next_ch]) begin
                shift_q <= {head[next_ch], {(SLOT_BITS - $bits(sample_t)){1'b0}}};
            end else begin
                shift_q <= '0;
            end
        end else if (bit_end) begin
            shift_q <= {shift_q[SLOT_BITS-2:0], 1'b0};
        end
    end

    // Word clock moves with the falling bck after the last bit of a slot.
    a_lrck_at_slot: assert property (
        @(posedge clk245760) disable iff (rst)
        $changed(i2s_lrck_o) |-> ($fell(i2s_bck_o) && $past(bit_q) == SLOT_BITS-1)
    );

endmodule

//--- hdl/upsample_dac_top.sv
`timescale 1ns/100ps

module upsample_dac_top import audio_pkg::*; (
    input  logic    clk245760,
    input  logic    rst,
    input  logic    locked_i,
    input  sample_t sample_i,
    input  ch_idx_t sample_ch_i,
    input  logic    sample_stb_i,
    output logic    i2s_bck_o,
    output logic    i2s_lrck_o,
    output logic    i2s_data_o
);

    chan_link_if links [NUM_CH] ();

    // Routes receiver samples, flushes while unlocked.
    frame_demux u_demux (
        .clk245760    (clk245760),
        .rst          (rst),
        .locked_i     (locked_i),
        .sample_i     (sample_i),
        .sample_ch_i  (sample_ch_i),
        .sample_stb_i (sample_stb_i),
        .links        (links)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        interp2x_ch u_ch (
            .clk245760 (clk245760),
            .rst       (rst),
            .link      (links[i])
        );
    end

    i2s_serializer u_ser (
        .clk245760  (clk245760),
        .rst        (rst),
        .links      (links),
        .i2s_bck_o  (i2s_bck_o),
        .i2s_lrck_o (i2s_lrck_o),
        .i2s_data_o (i2s_data_o)
    );

endmodule

//--- bench/upsample_dac_tb.sv
`timescale 1ns/100ps

module upsample_dac_tb import audio_pkg::*; ();

    localparam int N_STEP       = 4;
    localparam int N_RAND       = 8;
    localparam int SLOT_CYCLES  = SLOT_BITS * 2 * BCK_HALF;
    localparam int FRAMES_TOTAL = 4 + 4 + (2 * N_STEP + 4) + (2 * N_RAND + 6) + 12;
    localparam int TIMEOUT_NS   = FRAMES_TOTAL * 2 * SLOT_CYCLES * 10 * 2;

    logic    clk245760;
    logic    rst;
    logic    locked_i;
    sample_t sample_i;
    ch_idx_t sample_ch_i;
    logic    sample_stb_i;
    logic    i2s_bck_o;
    logic    i2s_lrck_o;
    logic    i2s_data_o;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng    = 32'd67411;

    // Reference queues, one per channel.
    sample_t model_l [$];
    sample_t model_r [$];
    sample_t prev_l = '0;
    sample_t prev_r = '0;

    // Decoded slots with the word expected at their start.
    ch_idx_t slot_ch   [$];
    sample_t slot_word [$];
    sample_t slot_exp  [$];

    logic    dec_lr = 1'b1;
    int      dec_pos = 0;
    sample_t dec_word = '0;
    sample_t dec_exp = '0;

    upsample_dac_top dut0 (
        .clk245760    (clk245760),
        .rst          (rst),
        .locked_i     (locked_i),
        .sample_i     (sample_i),
        .sample_ch_i  (sample_ch_i),
        .sample_stb_i (sample_stb_i),
        .i2s_bck_o    (i2s_bck_o),
        .i2s_lrck_o   (i2s_lrck_o),
        .i2s_data_o   (i2s_data_o)
    );

    initial begin
        clk245760 = 1'b0;
        forever #5 clk245760 = ~clk245760;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Floor of sum / 2, written without a shift.
    function automatic sample_t floor_half(input int sum);
        if (sum >= 0) begin
            return sample_t'(sum / 2);
        end
        return sample_t'(-((1 - sum) / 2));
    endfunction

    function automatic void model_push(input ch_idx_t ch, input sample_t s);
        if (ch == 1'b0) begin
            model_l.push_back(floor_half(int'(prev_l) + int'(s)));
            model_l.push_back(s);
            prev_l = s;
        end else begin
            model_r.push_back(floor_half(int'(prev_r) + int'(s)));
            model_r.push_back(s);
            prev_r = s;
        end
    endfunction

    function automatic void model_flush();
        model_l.delete();
        model_r.delete();
        prev_l = '0;
        prev_r = '0;
    endfunction

    // I2S decoder. Slot position 0 is the delay bit.
    always @(posedge i2s_bck_o) begin
        if (i2s_lrck_o != dec_lr) begin
            dec_lr  = i2s_lrck_o;
            dec_pos = 0;
            if (dec_lr == 1'b0) begin
                dec_exp = (model_l.size() > 0) ? model_l.pop_front() : '0;
            end else begin
                dec_exp = (model_r.size() > 0) ? model_r.pop_front() : '0;
            end
        end else begin
            dec_pos++;
        end
        if (dec_pos >= 1 && dec_pos <= 24) begin
            dec_word = {dec_word[22:0], i2s_data_o};
        end
        if (dec_pos == 24) begin
            slot_ch.push_back(ch_idx_t'(dec_lr));
            slot_word.push_back(dec_word);
            slot_exp.push_back(dec_exp);
        end
    end

    task automatic wait_lr_rise();
        logic last;
        logic found;
        int   n;
        last = i2s_lrck_o;
        n = 0;
        do begin
            @(posedge clk245760);
            #1;
            n++;
            found = !last && i2s_lrck_o;
            last  = i2s_lrck_o;
        end while (!found && n < 3 * SLOT_CYCLES);
        if (!found) begin
            $display("lrck did not rise within %0d cycles", 3 * SLOT_CYCLES);
            errors++;
        end
    endtask

    task automatic wait_frames(input int n);
        repeat (n) wait_lr_rise();
    endtask

    // One stereo push per two frames, in the middle of a right slot.
    task automatic push_frame(input logic do_l, input logic do_r, input sample_t l,
                              input sample_t r);
        wait_lr_rise();
        wait_lr_rise();
        repeat (SLOT_CYCLES / 2 - 1) @(posedge clk245760);
        #1;
        sample_i     = l;
        sample_ch_i  = 1'b0;
        sample_stb_i = do_l;
        if (do_l) model_push(1'b0, l);
        @(posedge clk245760);
        #1;
        sample_i     = r;
        sample_ch_i  = 1'b1;
        sample_stb_i = do_r;
        if (do_r) model_push(1'b1, r);
        @(posedge clk245760);
        #1;
        sample_stb_i = 1'b0;
    endtask

    task automatic check_slots(input string name, output int n, output sample_t first_l,
                               output sample_t first_r);
        ch_idx_t ch;
        sample_t word;
        sample_t exp;
        n = 0;
        first_l = '0;
        first_r = '0;
        while (slot_ch.size() > 0) begin
            ch   = slot_ch.pop_front();
            word = slot_word.pop_front();
            exp  = slot_exp.pop_front();
            n++;
            checks++;
            if (word != exp) begin
                $display("FAILED %s: %s slot expected %0d actual %0d", name,
                         (ch == 1'b0) ? "left" : "right", exp, word);
                errors++;
            end
            if (ch == 1'b0 && first_l == '0) first_l = word;
            if (ch == 1'b1 && first_r == '0) first_r = word;
        end
    endtask

    task automatic check_drained(input string name);
        checks++;
        if (model_l.size() != 0 || model_r.size() != 0) begin
            $display("%s: %0d left and %0d right words never reached the output", name,
                     model_l.size(), model_r.size());
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        $display("%s done, %0d errors", name, errors - errs0);
    endtask

    task automatic test_reset();
        int n;
        int errs0;
        errs0 = errors;
        rst = 1'b1;
        repeat (5) begin
            @(posedge clk245760);
            #1;
            checks++;
            if (i2s_bck_o || i2s_lrck_o || i2s_data_o) begin
                $display("reset: an I2S output is high during reset");
                errors++;
            end
        end
        rst = 1'b0;
        repeat (2) begin
            @(posedge clk245760);
            #1;
            checks++;
            if (i2s_bck_o || i2s_lrck_o || i2s_data_o) begin
                $display("reset: an I2S output is high right after reset");
                errors++;
            end
        end
        for (int k = 0; k < 5; k++) begin
            n = 0;
            do begin
                @(posedge clk245760);
                #1;
                n++;
            end while (i2s_lrck_o == k[0] && n < 3 * SLOT_CYCLES);
            checks++;
            if (k > 0 && n != SLOT_CYCLES) begin // First slot is entered from reset.
                $display("FAILED reset: lrck half period expected %0d actual %0d",
                         SLOT_CYCLES, n);
                errors++;
            end
        end
        report_test("reset", errs0);
    endtask

    task automatic test_underrun();
        int      n;
        int      errs0;
        sample_t fl;
        sample_t fr;
        errs0 = errors;
        wait_frames(3);
        check_slots("underrun", n, fl, fr);
        checks++;
        if (n < 4) begin
            $display("underrun: only %0d slots were decoded", n);
            errors++;
        end
        report_test("underrun", errs0);
    endtask

    task automatic test_step_left();
        int      n;
        int      errs0;
        sample_t fl;
        sample_t fr;
        errs0 = errors;
        for (int i = 0; i < N_STEP; i++) begin
            push_frame(1'b1, 1'b0, sample_t'((i + 1) * 'h100000), '0);
        end
        wait_frames(3);
        check_slots("step_left", n, fl, fr);
        checks += 2;
        if (fl != floor_half('h100000)) begin
            $display("FAILED step_left: first left word expected %0d actual %0d",
                     floor_half('h100000), fl);
            errors++;
        end
        if (fr != '0) begin
            $display("FAILED step_left: right slot expected 0 actual %0d", fr);
            errors++;
        end
        check_drained("step_left");
        report_test("step_left", errs0);
    endtask

    task automatic test_random();
        int      n;
        int      errs0;
        sample_t fl;
        sample_t fr;
        sample_t l;
        sample_t r;
        errs0 = errors;
        push_frame(1'b1, 1'b1, 24'sh800000, -24'sd3); // Full scale, odd negative sum.
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift32(rng);
            l   = sample_t'(rng[23:0]);
            rng = xorshift32(rng);
            r   = sample_t'(rng[31:8]);
            push_frame(1'b1, 1'b1, l, r);
        end
        wait_frames(3);
        check_slots("random", n, fl, fr);
        check_drained("random");
        report_test("random", errs0);
    endtask

    task automatic test_flush();
        int      n;
        int      errs0;
        sample_t fl;
        sample_t fr;
        sample_t new_l;
        sample_t new_r;
        errs0 = errors;
        new_l = -24'sd5;
        new_r = 24'sd1001;
        push_frame(1'b1, 1'b1, 24'sh123457, -24'sh0000a1);
        // Both midpoints are out, one sample waits in each queue.
        wait_lr_rise();
        repeat (SLOT_CYCLES / 2 - 1) @(posedge clk245760);
        #1;
        locked_i = 1'b0;
        model_flush();
        repeat (16) @(posedge clk245760);
        #1;
        sample_i     = 24'sh7fffff;
        sample_ch_i  = 1'b0;
        sample_stb_i = 1'b1;
        @(posedge clk245760);
        #1;
        sample_ch_i = 1'b1;
        @(posedge clk245760);
        #1;
        sample_stb_i = 1'b0;
        wait_frames(2);
        check_slots("flush", n, fl, fr);
        locked_i = 1'b1;
        push_frame(1'b1, 1'b1, new_l, new_r);
        wait_frames(3);
        check_slots("flush", n, fl, fr);
        checks += 2;
        if (fl != floor_half(int'(new_l))) begin
            $display("FAILED flush: first left midpoint expected %0d actual %0d",
                     floor_half(int'(new_l)), fl);
            errors++;
        end
        if (fr != floor_half(int'(new_r))) begin
            $display("FAILED flush: first right midpoint expected %0d actual %0d",
                     floor_half(int'(new_r)), fr);
            errors++;
        end
        check_drained("flush");
        report_test("flush", errs0);
    endtask

    initial begin
        rst          = 1'b1;
        locked_i     = 1'b1;
        sample_i     = '0;
        sample_ch_i  = 1'b0;
        sample_stb_i = 1'b0;
        test_reset();
        test_underrun();
        test_step_left();
        test_random();
        test_flush();
        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
hdl/audio_pkg.sv
hdl/chan_link_if.sv
hdl/frame_demux.sv
hdl/interp2x_ch.sv
hdl/i2s_serializer.sv
hdl/upsample_dac_top.sv
bench/upsample_dac_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then look for the fail message in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module upsample_dac_tb -f list.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
